/* verilog/tlul_pkg.sv */
`default_nettype none

package tlul_pkg;

  // Widths of the TL-UL fields used by this device port
  parameter int TL_AW  = 32;
  parameter int TL_DW  = 32;
  parameter int TL_DBW = TL_DW / 8;
  parameter int TL_SZW = 2;
  parameter int TL_AIW = 8;

  // Largest legal size field, as log2 of the bytes in one data word
  parameter int TL_SZ_MAX = $clog2(TL_DBW);

  // Byte address as seen on the A channel
  typedef logic [TL_AW-1:0] tl_addr_t;

  // One bus data word
  typedef logic [TL_DW-1:0] tl_data_t;

  // One enable bit per byte lane of the data word
  typedef logic [TL_DBW-1:0] tl_mask_t;

  // Access size as log2 of the number of bytes
  typedef logic [TL_SZW-1:0] tl_size_t;

  // Tag the host uses to match replies to requests
  typedef logic [TL_AIW-1:0] tl_source_t;

  // Request opcodes of TL-UL
  // Values outside this list are legal on the wires and get flagged by the checker
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // Reply opcodes of TL-UL
  // Writes and all errored requests get AccessAck, good reads get AccessAckData
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

endpackage

`default_nettype wire

/* verilog/sram_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sram_if #(
  parameter int SramAw = 10
);

  import tlul_pkg::*;

  // Command from the adapter, taken when req and gnt are both high
  logic              req;
  logic              we;
  logic [SramAw-1:0] addr;
  tl_data_t          wdata;
  tl_data_t          wmask;

  // Return from the memory
  // rvalid is a single-cycle pulse one cycle after a taken read
  logic     gnt;
  tl_data_t rdata;
  logic     rvalid;

  modport adapter (output req, we, addr, wdata, wmask, input gnt, rdata, rvalid);

  modport memory (input req, we, addr, wdata, wmask, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

/* verilog/fifo_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  // A depth of one still needs a one-bit pointer
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  count_q;
  logic             empty;
  logic             full;
  logic             bypass;
  logic             do_push;
  logic             do_pop;

  // Step a pointer around the circular buffer
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == CntW'(Depth));

  // With Pass set, an empty buffer hands the write side straight to the read side
  assign bypass = Pass && empty;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | (bypass & wvalid_i);
  assign rdata_o  = bypass ? wdata_i : mem[rptr_q];

  // A bypassed word that is taken in the same cycle never enters the buffer
  assign do_push = wvalid_i & ~full & ~(bypass & rready_i);
  assign do_pop  = rready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (do_pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      // Fill count only moves when exactly one side is active
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/tlul_err.sv */
`timescale 1ns/1ps
`default_nettype none

module tlul_err (
  input  logic                a_valid_i,
  input  tlul_pkg::tl_a_op_e  a_opcode_i,
  input  tlul_pkg::tl_size_t  a_size_i,
  input  tlul_pkg::tl_addr_t  a_address_i,
  input  tlul_pkg::tl_mask_t  a_mask_i,
  output logic                err_o
);

  import tlul_pkg::*;

  tl_mask_t lanes;
  logic     op_ok;
  logic     size_ok;
  logic     addr_ok;
  logic     mask_ok;

  // Only the three TL-UL opcodes this device understands are accepted
  assign op_ok = a_opcode_i inside {PutFullData, PutPartialData, Get};

  // The size may not exceed one data word
  assign size_ok = (a_size_i <= TL_SZW'(TL_SZ_MAX));

  // Work out the byte lanes selected by size and address, and the alignment
  always_comb begin
    lanes   = '0;
    addr_ok = 1'b0;
    case (a_size_i)
      2'd0: begin
        // Any byte address is aligned for a single byte
        lanes   = tl_mask_t'(4'b0001 << a_address_i[1:0]);
        addr_ok = 1'b1;
      end
      2'd1: begin
        lanes   = a_address_i[1] ? 4'b1100 : 4'b0011;
        addr_ok = ~a_address_i[0];
      end
      2'd2: begin
        lanes   = '1;
        addr_ok = (a_address_i[1:0] == 2'b00);
      end
      default: begin
        // Size 3 is already illegal, nothing is selected
        lanes   = '0;
        addr_ok = 1'b0;
      end
    endcase
  end

  // The mask may never reach outside the selected lanes
  // Get and PutFullData must enable exactly those lanes
  always_comb begin
    mask_ok = ((a_mask_i & ~lanes) == '0);
    if (a_opcode_i == Get || a_opcode_i == PutFullData) begin
      mask_ok = (a_mask_i == lanes);
    end
  end

  assign err_o = a_valid_i & ~(op_ok & size_ok & addr_ok & mask_ok);

endmodule

`default_nettype wire

/* verilog/tlul_sram_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_adapter #(
  parameter int SramAw      = 10,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  a_valid_i,
  input  tlul_pkg::tl_a_op_e    a_opcode_i,
  input  tlul_pkg::tl_size_t    a_size_i,
  input  tlul_pkg::tl_source_t  a_source_i,
  input  tlul_pkg::tl_addr_t    a_address_i,
  input  tlul_pkg::tl_mask_t    a_mask_i,
  input  tlul_pkg::tl_data_t    a_data_i,
  output logic                  a_ready_o,
  input  logic                  d_ready_i,
  output logic                  d_valid_o,
  output tlul_pkg::tl_d_op_e    d_opcode_o,
  output tlul_pkg::tl_size_t    d_size_o,
  output tlul_pkg::tl_source_t  d_source_o,
  output tlul_pkg::tl_data_t    d_data_o,
  output logic                  d_error_o,
  sram_if.adapter               sram
);

  import tlul_pkg::*;

  localparam int ByteBits = $clog2(TL_DBW);
  localparam int OpW      = $bits(tl_d_op_e);
  // Request FIFO entry is {reply opcode, error, size, source}
  localparam int ReqW     = OpW + 1 + TL_SZW + TL_AIW;

  // Widen every byte enable to eight bit enables
  function automatic tl_data_t expand_mask(input tl_mask_t m);
    tl_data_t bits;
    bits = '0;
    for (int i = 0; i < TL_DBW; i++) begin
      bits[8*i +: 8] = {8{m[i]}};
    end
    return bits;
  endfunction

  logic            a_ack;
  logic            d_ack;
  logic            sram_ack;
  logic            is_put;
  logic            is_get;
  logic            tlul_error;
  logic            wr_attr_error;
  logic            wr_vld_error;
  logic            rd_vld_error;
  logic            error_internal;
  logic            fifos_ready;
  tl_data_t        a_bitmask;
  tl_d_op_e        req_op;
  logic            reqfifo_wready;
  logic            reqfifo_rvalid;
  logic [ReqW-1:0] reqfifo_wdata;
  logic [ReqW-1:0] reqfifo_rdata;
  tl_d_op_e        head_op;
  logic            head_error;
  tl_size_t        head_size;
  tl_source_t      head_source;
  logic            head_is_read;
  logic            maskfifo_wvalid;
  logic            maskfifo_wready;
  logic            maskfifo_rvalid;
  tl_mask_t        maskfifo_rdata;
  logic            rspfifo_wvalid;
  logic            rspfifo_wready;
  logic            rspfifo_rvalid;
  logic            rspfifo_rready;
  tl_data_t        rspfifo_wdata;
  tl_data_t        rspfifo_rdata;
  logic            d_valid;

  assign is_put = a_opcode_i inside {PutFullData, PutPartialData};
  assign is_get = (a_opcode_i == Get);

  // Protocol legality of the A channel
  tlul_err u_err (
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .err_o       (tlul_error)
  );

  // Without byte access only whole-word writes are allowed
  assign wr_attr_error = is_put && !ByteAccess && (a_mask_i != '1 || a_size_i != 2'd2);
  assign wr_vld_error  = ErrOnWrite && !is_get;
  assign rd_vld_error  = ErrOnRead && is_get;
  assign error_internal = tlul_error | wr_attr_error | wr_vld_error | rd_vld_error;

  // All three FIFOs must have room before anything is accepted
  assign fifos_ready = reqfifo_wready & maskfifo_wready & rspfifo_wready;

  // Errored requests skip the memory, so they do not wait for a grant
  assign a_ready_o = (sram.gnt | error_internal) & fifos_ready;

  assign a_ack    = a_valid_i & a_ready_o;
  assign d_ack    = d_valid & d_ready_i;
  assign sram_ack = sram.req & sram.gnt;

  // SRAM command, raised only for legal requests
  assign a_bitmask  = expand_mask(a_mask_i);
  assign sram.req   = a_valid_i & fifos_ready & ~error_internal;
  assign sram.we    = is_put;
  assign sram.addr  = a_address_i[ByteBits +: SramAw];
  assign sram.wmask = a_bitmask;
  assign sram.wdata = is_put ? (a_data_i & a_bitmask) : '0;

  // The reply opcode is decided here and stored with the request
  assign req_op        = (is_get && !error_internal) ? AccessAckData : AccessAck;
  assign reqfifo_wdata = {req_op, error_internal, a_size_i, a_source_i};

  // Every accepted request gets one entry, popped by its D handshake
  fifo_sync #(
    .Width (ReqW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_reqfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (a_ack),
    .wready_o (reqfifo_wready),
    .wdata_i  (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (d_ack),
    .rdata_o  (reqfifo_rdata)
  );

  assign head_source  = reqfifo_rdata[TL_AIW-1:0];
  assign head_size    = reqfifo_rdata[TL_AIW +: TL_SZW];
  assign head_error   = reqfifo_rdata[TL_AIW + TL_SZW];
  assign head_op      = tl_d_op_e'(reqfifo_rdata[ReqW-1 -: OpW]);
  assign head_is_read = (head_op == AccessAckData);

  // Read mask waits here from the grant until the data returns
  assign maskfifo_wvalid = sram_ack & ~sram.we;

  fifo_sync #(
    .Width (TL_DBW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_maskfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (maskfifo_wvalid),
    .wready_o (maskfifo_wready),
    .wdata_i  (a_mask_i),
    .rvalid_o (maskfifo_rvalid),
    .rready_i (rspfifo_wvalid),
    .rdata_o  (maskfifo_rdata)
  );

  // Unrequested lanes of the read word come back as zero
  assign rspfifo_wvalid = sram.rvalid & maskfifo_rvalid;
  assign rspfifo_wdata  = sram.rdata & expand_mask(maskfifo_rdata);
  assign rspfifo_rready = d_ack & head_is_read;

  // The memory cannot be stalled, so read data is parked here under back-pressure
  fifo_sync #(
    .Width (TL_DW),
    .Depth (Outstanding),
    .Pass  (1'b1)
  ) u_rspfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (rspfifo_wvalid),
    .wready_o (rspfifo_wready),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

  // A read reply waits for its data, anything else answers at once
  assign d_valid = reqfifo_rvalid & (~head_is_read | rspfifo_rvalid);

  assign d_valid_o  = d_valid;
  assign d_opcode_o = d_valid ? head_op : AccessAck;
  assign d_size_o   = d_valid ? head_size : '0;
  assign d_source_o = d_valid ? head_source : '0;
  assign d_data_o   = (d_valid && head_is_read) ? rspfifo_rdata : '0;
  assign d_error_o  = d_valid & head_error;

endmodule

`default_nettype wire

/* verilog/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int SramAw = 10
) (
  input  logic     clk_i,
  input  logic     rst_i,
  sram_if.memory   sram
);

  import tlul_pkg::*;

  tl_data_t mem [2**SramAw];
  tl_data_t rdata_q;
  logic     rvalid_q;
  logic     gnt_q;
  logic     take_wr;
  logic     take_rd;

  assign take_wr = sram.req & sram.gnt & sram.we;
  assign take_rd = sram.req & sram.gnt & ~sram.we;

  // Grant drops for the one cycle that follows an accepted write
  // Read returns pulse rvalid one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q    <= 1'b1;
      rvalid_q <= 1'b0;
    end else begin
      gnt_q    <= ~take_wr;
      rvalid_q <= take_rd;
    end
  end

  // Array access, written through the bit mask
  always_ff @(posedge clk_i) begin
    if (take_wr) begin
      mem[sram.addr] <= (mem[sram.addr] & ~sram.wmask) | (sram.wdata & sram.wmask);
    end
    if (take_rd) begin
      rdata_q <= mem[sram.addr];
    end
  end

  assign sram.gnt    = gnt_q;
  assign sram.rvalid = rvalid_q;
  assign sram.rdata  = rdata_q;

endmodule

`default_nettype wire

/* verilog/tlul_sram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_top #(
  parameter int SramAw      = 10,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  a_valid_i,
  input  tlul_pkg::tl_a_op_e    a_opcode_i,
  input  tlul_pkg::tl_size_t    a_size_i,
  input  tlul_pkg::tl_source_t  a_source_i,
  input  tlul_pkg::tl_addr_t    a_address_i,
  input  tlul_pkg::tl_mask_t    a_mask_i,
  input  tlul_pkg::tl_data_t    a_data_i,
  output logic                  a_ready_o,
  input  logic                  d_ready_i,
  output logic                  d_valid_o,
  output tlul_pkg::tl_d_op_e    d_opcode_o,
  output tlul_pkg::tl_size_t    d_size_o,
  output tlul_pkg::tl_source_t  d_source_o,
  output tlul_pkg::tl_data_t    d_data_o,
  output logic                  d_error_o
);

  // Command and return wires between the adapter and the memory
  sram_if #(.SramAw(SramAw)) sram_bus ();

  tlul_sram_adapter #(
    .SramAw      (SramAw),
    .Outstanding (Outstanding),
    .ByteAccess  (ByteAccess),
    .ErrOnWrite  (ErrOnWrite),
    .ErrOnRead   (ErrOnRead)
  ) u_adapter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .a_ready_o   (a_ready_o),
    .d_ready_i   (d_ready_i),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .sram        (sram_bus.adapter)
  );

  // Upper address bits are ignored, so the memory aliases across the space
  sram_model #(
    .SramAw (SramAw)
  ) u_sram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .sram  (sram_bus.memory)
  );

endmodule

`default_nettype wire

/* testbench/tlul_sram_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_assertions (
  input logic                 clk_i,
  input logic                 rst_i,
  input tlul_pkg::tl_a_op_e   a_opcode_i,
  input tlul_pkg::tl_size_t   a_size_i,
  input tlul_pkg::tl_addr_t   a_address_i,
  input logic                 d_valid_i,
  input logic                 d_ready_i,
  input tlul_pkg::tl_d_op_e   d_opcode_i,
  input tlul_pkg::tl_size_t   d_size_i,
  input tlul_pkg::tl_source_t d_source_i,
  input tlul_pkg::tl_data_t   d_data_i,
  input logic                 d_error_i,
  input logic                 sram_req_i,
  input logic                 sram_gnt_i,
  input logic                 sram_we_i,
  input logic                 sram_rvalid_i,
  input logic                 mask_rvalid_i,
  input logic                 rsp_wready_i
);

  import tlul_pkg::*;

  // A stalled reply keeps every field until the host takes it
  d_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (d_valid_i && !d_ready_i) |=> (d_valid_i && $stable(d_opcode_i) && $stable(d_size_i)
      && $stable(d_source_i) && $stable(d_data_i) && $stable(d_error_i)))
    else $error("D channel fields changed during a stall");

  // Requests with a bad opcode, size or alignment never reach the memory
  no_err_req: assert property (@(posedge clk_i) disable iff (rst_i)
    sram_req_i |-> ((a_opcode_i inside {PutFullData, PutPartialData, Get})
      && (a_size_i != 2'd3)
      && !(a_size_i == 2'd1 && a_address_i[0])
      && !(a_size_i == 2'd2 && a_address_i[1:0] != 2'b00)))
    else $error("SRAM request raised for an errored request");

  // Read data comes back exactly one cycle after a granted read
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
    sram_rvalid_i |-> $past(sram_req_i && sram_gnt_i && !sram_we_i))
    else $error("rvalid without a granted read in the cycle before");

  // Returned read data always finds its mask and room in the response FIFO
  read_data_kept: assert property (@(posedge clk_i) disable iff (rst_i)
    sram_rvalid_i |-> (mask_rvalid_i && rsp_wready_i))
    else $error("read data returned with no mask waiting or no room to park it");

endmodule

bind tlul_sram_adapter tlul_sram_assertions u_assertions (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .a_opcode_i    (a_opcode_i),
  .a_size_i      (a_size_i),
  .a_address_i   (a_address_i),
  .d_valid_i     (d_valid_o),
  .d_ready_i     (d_ready_i),
  .d_opcode_i    (d_opcode_o),
  .d_size_i      (d_size_o),
  .d_source_i    (d_source_o),
  .d_data_i      (d_data_o),
  .d_error_i     (d_error_o),
  .sram_req_i    (sram.req),
  .sram_gnt_i    (sram.gnt),
  .sram_we_i     (sram.we),
  .sram_rvalid_i (sram.rvalid),
  .mask_rvalid_i (maskfifo_rvalid),
  .rsp_wready_i  (rspfifo_wready)
);

`default_nettype wire

/* testbench/tb_tlul_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tlul_sram;

  import tlul_pkg::*;

  localparam int SramAw      = 10;
  localparam int Words       = 2 ** SramAw;
  localparam int NumRequests = 300;
  localparam int RandomCount = 220;
  // Every request gets a generous ten cycles plus room for reset and drain
  localparam int CycleLimit  = NumRequests * 10 + 100;

  // One expected D-channel reply
  typedef struct packed {
    tl_d_op_e   op;
    logic       error;
    tl_size_t   size;
    tl_source_t source;
    tl_data_t   data;
  } reply_t;

  logic       clk;
  logic       rst;
  logic       a_valid;
  tl_a_op_e   a_opcode;
  tl_size_t   a_size;
  tl_source_t a_source;
  tl_addr_t   a_address;
  tl_mask_t   a_mask;
  tl_data_t   a_data;
  logic       a_ready;
  logic       d_ready;
  logic       d_valid;
  tl_d_op_e   d_opcode;
  tl_size_t   d_size;
  tl_source_t d_source;
  tl_data_t   d_data;
  logic       d_error;

  // Shadow copy of the SRAM and the in-order list of expected replies
  tl_data_t    shadow [Words];
  reply_t      expected_q [NumRequests];
  int          push_count;
  int          pop_count;
  int          cycle_count;
  logic [31:0] lfsr_state;

  tlul_sram_top u_tlul_sram_top (
    .clk_i       (clk),
    .rst_i       (rst),
    .a_valid_i   (a_valid),
    .a_opcode_i  (a_opcode),
    .a_size_i    (a_size),
    .a_source_i  (a_source),
    .a_address_i (a_address),
    .a_mask_i    (a_mask),
    .a_data_i    (a_data),
    .a_ready_o   (a_ready),
    .d_ready_i   (d_ready),
    .d_valid_o   (d_valid),
    .d_opcode_o  (d_opcode),
    .d_size_o    (d_size),
    .d_source_o  (d_source),
    .d_data_o    (d_data),
    .d_error_o   (d_error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1 and one step per bit handed out
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  // Byte lanes covered by an access of 2^size bytes starting at the address
  function automatic tl_mask_t size_lanes(input tl_size_t size, input tl_addr_t addr);
    tl_mask_t lanes;
    int       first;
    int       count;
    lanes = '0;
    first = int'(addr[1:0]);
    count = 1 << size;
    for (int i = 0; i < TL_DBW; i++) begin
      if (i >= first && i < first + count) begin
        lanes[i] = 1'b1;
      end
    end
    return lanes;
  endfunction

  // Initial word contents spread over the whole address
  function automatic tl_data_t fill_word(input tl_addr_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // Reference model that judges legality, updates the shadow and returns the reply
  function automatic reply_t model_request(input tl_a_op_e op, input tl_size_t size,
      input tl_source_t source, input tl_addr_t addr, input tl_mask_t mask,
      input tl_data_t data);
    reply_t   rsp;
    tl_mask_t lanes;
    logic     legal;
    int       index;
    lanes = size_lanes(size, addr);
    legal = (op == PutFullData) || (op == PutPartialData) || (op == Get);
    if (size > 2'd2) begin
      legal = 1'b0;
    end
    if ((int'(addr[1:0]) % (1 << size)) != 0) begin
      legal = 1'b0;
    end
    if ((mask & ~lanes) != '0) begin
      legal = 1'b0;
    end
    if ((op == Get || op == PutFullData) && mask != lanes) begin
      legal = 1'b0;
    end
    // Addresses wrap at the SRAM size in bytes
    index      = int'((addr % tl_addr_t'(TL_DBW * Words)) / tl_addr_t'(TL_DBW));
    rsp.op     = AccessAck;
    rsp.error  = ~legal;
    rsp.size   = size;
    rsp.source = source;
    rsp.data   = '0;
    for (int b = 0; b < TL_DBW; b++) begin
      if (legal && mask[b] && op == Get) begin
        rsp.data[8*b +: 8] = shadow[index][8*b +: 8];
      end else if (legal && mask[b]) begin
        shadow[index][8*b +: 8] = data[8*b +: 8];
      end
    end
    if (legal && op == Get) begin
      rsp.op = AccessAckData;
    end
    return rsp;
  endfunction

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_data(input tl_data_t got, input tl_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch d_data_o got 0x%08h expected 0x%08h", got, exp));
    end
  endtask

  task automatic check_tag(input tl_source_t got_source, input tl_source_t exp_source,
      input tl_size_t got_size, input tl_size_t exp_size);
    if (got_source !== exp_source) begin
      report_failure($sformatf("mismatch d_source_o got 0x%02h expected 0x%02h",
                               got_source, exp_source));
    end else if (got_size !== exp_size) begin
      report_failure($sformatf("mismatch d_size_o got 0x%0h expected 0x%0h",
                               got_size, exp_size));
    end
  endtask

  task automatic check_kind(input tl_d_op_e got_op, input tl_d_op_e exp_op,
      input logic got_error, input logic exp_error);
    if (got_op !== exp_op) begin
      report_failure($sformatf("mismatch d_opcode_o got 0x%0h expected 0x%0h", got_op, exp_op));
    end else if (got_error !== exp_error) begin
      report_failure($sformatf("mismatch d_error_o got 0x%0h expected 0x%0h",
                               got_error, exp_error));
    end
  endtask

  // One rising edge with a fresh random d_ready for the coming cycle
  task automatic tick();
    @(posedge clk);
    d_ready <= (take_bits(2) != '0);
  endtask

  // Drives one request and waits for a_ready
  // The transfer happens at the next edge
  task automatic send_request(input tl_a_op_e op, input tl_size_t size,
      input tl_source_t source, input tl_addr_t addr, input tl_mask_t mask,
      input tl_data_t data);
    logic accepted;
    tick();
    a_valid   <= 1'b1;
    a_opcode  <= op;
    a_size    <= size;
    a_source  <= source;
    a_address <= addr;
    a_mask    <= mask;
    a_data    <= data;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (a_ready) begin
        expected_q[push_count] = model_request(op, size, source, addr, mask, data);
        push_count++;
        accepted = 1'b1;
      end else begin
        tick();
      end
    end
  endtask

  task automatic idle_cycle();
    tick();
    a_valid <= 1'b0;
  endtask

  task automatic read_word(input tl_addr_t addr, input tl_source_t source);
    send_request(Get, 2'd2, source, addr, 4'hF, '0);
  endtask

  // Mostly legal requests on 16 words with random upper address bits for aliasing
  task automatic random_request();
    tl_a_op_e   op;
    tl_size_t   size;
    tl_addr_t   addr;
    tl_mask_t   mask;
    logic [1:0] offset;
    case (3'(take_bits(3)))
      3'd0, 3'd1, 3'd2: op = Get;
      3'd3, 3'd4:       op = PutFullData;
      3'd5, 3'd6:       op = PutPartialData;
      default:          op = tl_a_op_e'(3'(take_bits(3)));
    endcase
    size   = tl_size_t'(take_bits(2));
    offset = 2'(take_bits(2));
    if (take_bits(2) != '0) begin
      if (size == 2'd1) begin
        offset[0] = 1'b0;
      end
      if (size == 2'd2) begin
        offset = 2'b00;
      end
    end
    addr = (take_bits(20) << 12) | (take_bits(4) << 2) | tl_addr_t'(offset);
    mask = size_lanes(size, addr);
    if (op == PutPartialData) begin
      mask = mask & tl_mask_t'(take_bits(4));
    end
    // Now and then a raw mask that is usually illegal
    if (take_bits(3) == '0) begin
      mask = tl_mask_t'(take_bits(4));
    end
    send_request(op, size, tl_source_t'(take_bits(8)), addr, mask, take_bits(32));
    if (take_bits(2) == '0) begin
      idle_cycle();
    end
  endtask

  // Compares every D handshake with the oldest expected reply
  always @(negedge clk) begin
    if (rst) begin
      pop_count = 0;
    end else if (d_valid && d_ready) begin
      if (pop_count >= push_count) begin
        report_failure("a reply arrived with no request outstanding");
      end else begin
        check_kind(d_opcode, expected_q[pop_count].op, d_error, expected_q[pop_count].error);
        check_tag(d_source, expected_q[pop_count].source, d_size, expected_q[pop_count].size);
        check_data(d_data, expected_q[pop_count].data);
        pop_count++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
    if (cycle_count > CycleLimit) begin
      report_failure($sformatf("the run did not finish within %0d cycles", CycleLimit));
    end
  end

  initial begin
    lfsr_state = 32'd84417;
    push_count = 0;
    a_valid    = 1'b0;
    a_opcode   = Get;
    a_size     = '0;
    a_source   = '0;
    a_address  = '0;
    a_mask     = '0;
    a_data     = '0;
    d_ready    = 1'b0;
    rst        = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (d_valid) begin
      report_failure("d_valid was high right after reset");
    end

    // Whole-word writes to the 16 test words, then read them all back
    for (int w = 0; w < 16; w++) begin
      send_request(PutFullData, 2'd2, 8'(w), tl_addr_t'(4 * w), 4'hF, fill_word(4 * w));
    end
    for (int w = 0; w < 16; w++) begin
      read_word(tl_addr_t'(4 * w), 8'(8'h40 + w));
    end

    // Partial writes with sparse masks, then full and sub-word reads
    send_request(PutPartialData, 2'd2, 8'h80, 32'h08, 4'b0101, 32'h1122_3344);
    send_request(PutPartialData, 2'd2, 8'h81, 32'h0C, 4'b1000, 32'hAABB_CCDD);
    send_request(PutPartialData, 2'd0, 8'h82, 32'h12, 4'b0100, 32'h00EE_0000);
    send_request(PutPartialData, 2'd1, 8'h83, 32'h16, 4'b1000, 32'h7700_0000);
    send_request(PutPartialData, 2'd2, 8'h84, 32'h18, 4'b0010, 32'h0000_9900);
    for (int w = 2; w < 7; w++) begin
      read_word(tl_addr_t'(4 * w), 8'(8'h88 + w));
    end
    send_request(Get, 2'd0, 8'h90, 32'h09, 4'b0010, '0);
    send_request(Get, 2'd1, 8'h91, 32'h0E, 4'b1100, '0);
    send_request(Get, 2'd0, 8'h92, 32'h13, 4'b1000, '0);

    // Illegal requests each answered with an error and no memory access
    send_request(PutFullData, 2'd2, 8'hA0, 32'h1D, 4'hF, 32'hDEAD_0001);
    send_request(PutFullData, 2'd3, 8'hA1, 32'h20, 4'hF, 32'hDEAD_0002);
    send_request(PutPartialData, 2'd1, 8'hA2, 32'h24, 4'b0100, 32'hDEAD_0003);
    send_request(Get, 2'd2, 8'hA3, 32'h28, 4'b0011, '0);
    send_request(tl_a_op_e'(3'h2), 2'd2, 8'hA4, 32'h2C, 4'hF, 32'hDEAD_0004);
    send_request(tl_a_op_e'(3'h7), 2'd2, 8'hA5, 32'h2C, 4'hF, 32'hDEAD_0005);
    send_request(Get, 2'd1, 8'hA6, 32'h31, 4'b0110, '0);
    read_word(32'h1C, 8'hB0);
    read_word(32'h20, 8'hB1);
    read_word(32'h24, 8'hB2);
    read_word(32'h2C, 8'hB3);

    // A high address lands on the same word as its low alias
    send_request(PutFullData, 2'd2, 8'hC0, 32'h0001_0034, 4'hF, 32'h0BAD_F00D);
    read_word(32'hFFFF_F034, 8'hC1);
    read_word(32'h0000_0034, 8'hC2);

    // Random traffic with back-pressure and back-to-back requests
    for (int n = 0; n < RandomCount; n++) begin
      random_request();
    end
    idle_cycle();

    while (pop_count < push_count) begin
      tick();
    end
    repeat (5) tick();
    // Every request is answered, so no further reply may be offered
    @(negedge clk);
    if (d_valid) begin
      report_failure("a reply was still offered after every request was answered");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tlul_sram.f */
verilog/tlul_pkg.sv
verilog/sram_if.sv
verilog/fifo_sync.sv
verilog/tlul_err.sv
verilog/tlul_sram_adapter.sv
verilog/sram_model.sv
verilog/tlul_sram_top.sv
testbench/tlul_sram_assertions.sv
testbench/tb_tlul_sram.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_tlul_sram
FILELIST ?= tlul_sram.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
